//--- sources.f
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_icache -o tb_icache_sim \
    && ./obj_dir/tb_icache_sim | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb_icache.sv
`default_nettype none

module tb_icache;
    localparam logic [31:0] PATTERN = 32'h5a3c_96e1;
    localparam int          LIMIT   = 5000;

    logic        clk;
    logic        rst_n;
    logic        fetch_req_i;
    logic [31:0] fetch_addr_i;
    logic        busy_o;
    logic        resp_valid_o;
    logic [31:0] resp_addr_o;
    logic [63:0] resp_data_o;
    logic        mem_addr_valid_o;
    logic [31:0] mem_addr_o;
    logic        mem_addr_ready_i;
    logic        mem_data_valid_i;
    logic [31:0] mem_data_i;

    logic [31:0] exp_addr_q [$];
    int          exp_cycle_q [$];
    bit          exp_hit_q [$];
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    int          bus_reqs = 0;
    bit          busy_seen = 1'b0;
    bit          req_prev1 = 1'b0;
    bit          req_prev2 = 1'b0;
    logic [31:0] last_bus_addr = '0;
    logic [31:0] fill_base = '0;
    int          beats_left = 0;
    int          beat_idx = 0;

    icache_top icache_top_inst (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ PATTERN;
    endfunction

    function automatic logic [63:0] pair_at(input logic [31:0] a);
        return {word_at(a + 32'd4), word_at(a)};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    reset_clears: assert property (@(posedge clk)
        !rst_n |=> !busy_o && !resp_valid_o && !mem_addr_valid_o)
    else begin
        errors++;
        $display("outputs not cleared by reset at time %0t", $time);
    end

    // every response carries the pattern pair for its own address
    resp_pattern: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o |-> resp_data_o == pair_at(resp_addr_o))
    else begin
        errors++;
        $display("FAIL time=%0t resp_data_o got=%h expected=%h",
                 $time, $sampled(resp_data_o), pair_at($sampled(resp_addr_o)));
    end

    // memory model with random accept and random gaps between beats
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_addr_ready_i <= 1'b0;
            mem_data_valid_i <= 1'b0;
            beats_left = 0;
        end else begin
            mem_data_valid_i <= 1'b0;
            if (beats_left > 0 && $urandom % 4 != 0) begin
                mem_data_valid_i <= 1'b1;
                mem_data_i       <= word_at(fill_base + 32'(4 * beat_idx));
                beat_idx++;
                beats_left--;
            end
            if (mem_addr_valid_o && mem_addr_ready_i) begin
                fill_base     = mem_addr_o;
                last_bus_addr = mem_addr_o;
                beat_idx      = 0;
                beats_left    = 8;
                bus_reqs++;
            end
            mem_addr_ready_i <= ($urandom % 3 == 0);
        end
    end

    // responses checked mid cycle where outputs are settled
    always @(negedge clk) begin : check_resp
        logic [31:0] ea;
        int          ec;
        bit          eh;
        if (rst_n && resp_valid_o) begin
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("response with no request outstanding at time %0t", $time);
            end else begin
                ea = exp_addr_q.pop_front();
                ec = exp_cycle_q.pop_front();
                eh = exp_hit_q.pop_front();
                check_value("resp_addr_o", 64'(resp_addr_o), 64'(ea));
                check_value("resp_data_o", resp_data_o, pair_at(ea));
                if (eh) begin
                    check_value("hit latency", 64'(cycle_cnt - ec), 64'd2);
                end
            end
        end
        busy_seen = busy_o;
        req_prev2 = req_prev1;
        req_prev1 = fetch_req_i;
        cycle_cnt++;
    end

    task automatic idle_cycle();
        @(posedge clk);
        fetch_req_i <= 1'b0;
    endtask

    // a strobe two cycles after a request could land just as busy_o rises
    task automatic fetch(input logic [31:0] addr, input bit hit);
        int n;
        n = 0;
        @(posedge clk);
        while ((busy_seen || req_prev2) && n < LIMIT) begin
            fetch_req_i <= 1'b0;
            n++;
            @(posedge clk);
        end
        if (n >= LIMIT) begin
            $display("timeout waiting for the cache to accept a fetch");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            fetch_req_i  <= 1'b1;
            fetch_addr_i <= addr;
            exp_addr_q.push_back(addr);
            exp_cycle_q.push_back(cycle_cnt);
            exp_hit_q.push_back(hit);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle_cycle();
        while ((exp_addr_q.size() != 0 || busy_seen) && n < LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (n >= LIMIT) begin
            $display("timeout waiting for outstanding responses");
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int e;
        int b;
        logic [31:0] a;
        void'($urandom(32'h348e_e942));
        clk              = 1'b0;
        rst_n            = 1'b0;
        fetch_req_i      = 1'b0;
        fetch_addr_i     = '0;
        mem_addr_ready_i = 1'b0;
        mem_data_valid_i = 1'b0;
        mem_data_i       = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        e = errors;
        @(negedge clk);
        check_value("busy_o", 64'(busy_o), 64'd0);
        check_value("resp_valid_o", 64'(resp_valid_o), 64'd0);
        check_value("mem_addr_valid_o", 64'(mem_addr_valid_o), 64'd0);
        end_test("reset", e);

        e = errors;
        b = bus_reqs;
        fetch(32'h0000_4010, 1'b0);
        drain();
        check_value("mem_addr_o", 64'(last_bus_addr), 64'h4000);
        check_value("bus requests", 64'(bus_reqs - b), 64'd1);
        end_test("cold_miss", e);

        e = errors;
        b = bus_reqs;
        fetch(32'h0000_4018, 1'b1);
        drain();
        fetch(32'h0000_4000, 1'b1);
        drain();
        check_value("bus requests", 64'(bus_reqs - b), 64'd0);
        end_test("same_block_hit", e);

        // three tags on set 5
        e = errors;
        fetch(32'h0001_00a0, 1'b0);
        drain();
        fetch(32'h0002_00a8, 1'b0);
        drain();
        fetch(32'h0003_00b0, 1'b0);
        drain();
        b = bus_reqs;
        fetch(32'h0002_00b8, 1'b1);
        drain();
        check_value("bus requests", 64'(bus_reqs - b), 64'd0);
        fetch(32'h0001_00a0, 1'b0);
        drain();
        check_value("bus requests", 64'(bus_reqs - b), 64'd1);
        end_test("victim_alternates", e);

        e = errors;
        fetch(32'h0000_4008, 1'b1);
        fetch(32'h0000_4010, 1'b1);
        drain();
        fetch(32'h0000_6000, 1'b0);
        fetch(32'h0000_7008, 1'b0);
        drain();
        end_test("back_to_back", e);

        e = errors;
        for (int i = 0; i < 200; i++) begin
            a = 32'h0002_0000 + (($urandom % 4) << 12) + (($urandom % 4) << 5)
                + (($urandom % 4) << 3);
            fetch(a, 1'b0);
            if ($urandom % 3 == 0) begin
                idle_cycle();
            end
        end
        drain();
        end_test("random_stream", e);

        $display("tests run %0d, failed %0d, errors %0d, checker failures %0d",
                 tests_run, tests_failed, errors, icache_top_inst.checker_inst.fail_cnt);
        if (errors == 0 && tests_failed == 0 && icache_top_inst.checker_inst.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_checker.sv
`default_nettype none

module icache_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_addr_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic                          mem_addr_ready_i,
    input  logic                          resp_valid_i
);
    int fail_cnt = 0;

    // address must not move while the request waits for ready
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_addr_valid_i && !mem_addr_ready_i |=> mem_addr_valid_i && $stable(mem_addr_i))
    else begin
        $error("memory request dropped or changed before it was accepted");
        fail_cnt++;
    end

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        mem_addr_valid_i |-> mem_addr_i[4:0] == 5'd0)
    else begin
        $error("memory request address is not block aligned");
        fail_cnt++;
    end

    no_resp_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_addr_valid_i |-> !resp_valid_i)
    else begin
        $error("fetch response seen while a memory request is open");
        fail_cnt++;
    end

endmodule

bind icache_top icache_checker checker_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .mem_addr_valid_i (mem_addr_valid_o),
    .mem_addr_i       (mem_addr_o),
    .mem_addr_ready_i (mem_addr_ready_i),
    .resp_valid_i     (resp_valid_o)
);

`default_nettype wire

//--- icache_top.sv
`default_nettype none

module icache_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
    output logic                              busy_o,
    output logic                              resp_valid_o,
    output logic [icache_pkg::ADDR_W-1:0]     resp_addr_o,
    output logic [icache_pkg::PAIR_W-1:0]     resp_data_o,
    output logic                              mem_addr_valid_o,
    output logic [icache_pkg::ADDR_W-1:0]     mem_addr_o,
    input  logic                              mem_addr_ready_i,
    input  logic                              mem_data_valid_i,
    input  logic [icache_pkg::WORD_W-1:0]     mem_data_i
);
    import icache_pkg::*;

    // array read side
    logic [INDEX_W-1:0]                rd_index;
    logic [PAIR_SEL_W-1:0]             rd_pair;
    logic [WAY_NUM-1:0][TAG_W-1:0]     rd_tag;
    logic [WAY_NUM-1:0]                rd_valid;
    logic [WAY_NUM-1:0][PAIR_W-1:0]    rd_data;

    // refill write side
    logic [WAY_NUM-1:0]                tag_wr_en;
    logic [INDEX_W-1:0]                tag_wr_index;
    logic [TAG_W-1:0]                  tag_wr_tag;
    logic [WAY_NUM-1:0]                data_wr_en;
    logic [INDEX_W-1:0]                data_wr_index;
    logic [PAIR_SEL_W-1:0]             data_wr_pair;
    logic [PAIR_W-1:0]                 data_wr_data;

    logic                              miss;
    logic [ADDR_W-1:0]                 miss_addr;
    logic                              hold;
    logic                              refill_done;
    logic [PAIR_W-1:0]                 fill_data;

    icache_tag_ram tag_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .rd_tag_o   (rd_tag),
        .rd_valid_o (rd_valid),
        .wr_en_i    (tag_wr_en),
        .wr_index_i (tag_wr_index),
        .wr_tag_i   (tag_wr_tag)
    );

    icache_data_ram data_ram_inst (
        .clk        (clk),
        .rd_index_i (rd_index),
        .rd_pair_i  (rd_pair),
        .rd_data_o  (rd_data),
        .wr_en_i    (data_wr_en),
        .wr_index_i (data_wr_index),
        .wr_pair_i  (data_wr_pair),
        .wr_data_i  (data_wr_data)
    );

    icache_lookup lookup_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .rd_index_o    (rd_index),
        .rd_pair_o     (rd_pair),
        .rd_tag_i      (rd_tag),
        .rd_valid_i    (rd_valid),
        .rd_data_i     (rd_data),
        .miss_o        (miss),
        .miss_addr_o   (miss_addr),
        .hold_o        (hold),
        .refill_done_i (refill_done),
        .fill_data_i   (fill_data),
        .resp_valid_o  (resp_valid_o),
        .resp_addr_o   (resp_addr_o),
        .resp_data_o   (resp_data_o)
    );

    icache_refill refill_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .miss_i           (miss),
        .miss_addr_i      (miss_addr),
        .hold_i           (hold),
        .mem_addr_valid_o (mem_addr_valid_o),
        .mem_addr_o       (mem_addr_o),
        .mem_addr_ready_i (mem_addr_ready_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .tag_wr_en_o      (tag_wr_en),
        .tag_wr_index_o   (tag_wr_index),
        .tag_wr_tag_o     (tag_wr_tag),
        .data_wr_en_o     (data_wr_en),
        .data_wr_index_o  (data_wr_index),
        .data_wr_pair_o   (data_wr_pair),
        .data_wr_data_o   (data_wr_data),
        .fill_data_o      (fill_data),
        .refill_done_o    (refill_done),
        .busy_o           (busy_o)
    );

endmodule

`default_nettype wire

//--- icache_refill.sv
`default_nettype none

module icache_refill (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   miss_i,
    input  logic [icache_pkg::ADDR_W-1:0]          miss_addr_i,
    input  logic                                   hold_i,
    output logic                                   mem_addr_valid_o,
    output logic [icache_pkg::ADDR_W-1:0]          mem_addr_o,
    input  logic                                   mem_addr_ready_i,
    input  logic                                   mem_data_valid_i,
    input  logic [icache_pkg::WORD_W-1:0]          mem_data_i,
    output logic [icache_pkg::WAY_NUM-1:0]         tag_wr_en_o,
    output logic [icache_pkg::INDEX_W-1:0]         tag_wr_index_o,
    output logic [icache_pkg::TAG_W-1:0]           tag_wr_tag_o,
    output logic [icache_pkg::WAY_NUM-1:0]         data_wr_en_o,
    output logic [icache_pkg::INDEX_W-1:0]         data_wr_index_o,
    output logic [icache_pkg::PAIR_SEL_W-1:0]      data_wr_pair_o,
    output logic [icache_pkg::PAIR_W-1:0]          data_wr_data_o,
    output logic [icache_pkg::PAIR_W-1:0]          fill_data_o,
    output logic                                   refill_done_o,
    output logic                                   busy_o
);
    import icache_pkg::*;

    refill_state_e                    state_q;
    refill_state_e                    state_d;
    logic [$clog2(BLOCK_WORDS)-1:0]   beat_cnt_q;
    fetch_addr_u                      addr_q;
    logic [WORD_W-1:0]                low_word_q;
    logic [PAIR_W-1:0]                fill_q;
    logic [SET_NUM-1:0]               victim_q;
    logic [WAY_NUM-1:0]               victim_oh;
    logic                             start;
    logic                             beat;
    logic                             pair_done;
    logic                             pair_match;
    logic                             last_beat;
    logic [PAIR_W-1:0]                pair_data;

    assign start      = miss_i && (state_q == IDLE || state_q == DONE);
    assign beat       = (state_q == FILL) && mem_data_valid_i;
    assign pair_done  = beat && beat_cnt_q[0];
    assign last_beat  = beat && (&beat_cnt_q);
    assign pair_data  = {mem_data_i, low_word_q};
    assign pair_match = beat_cnt_q[PAIR_SEL_W:1] == addr_q.f.pair;
    assign victim_oh  = WAY_NUM'(1) << victim_q[addr_q.f.index];

    // block-aligned request, held through REQ
    assign mem_addr_valid_o = (state_q == REQ);
    assign mem_addr_o       = {addr_q.f.tag, addr_q.f.index, {(ADDR_W-TAG_W-INDEX_W){1'b0}}};

    // each second beat completes a pair
    assign data_wr_en_o    = pair_done ? victim_oh : '0;
    assign data_wr_index_o = addr_q.f.index;
    assign data_wr_pair_o  = beat_cnt_q[PAIR_SEL_W:1];
    assign data_wr_data_o  = pair_data;

    assign tag_wr_en_o    = last_beat ? victim_oh : '0;
    assign tag_wr_index_o = addr_q.f.index;
    assign tag_wr_tag_o   = addr_q.f.tag;

    // requested pair may be the one completing right now
    assign fill_data_o   = (pair_done && pair_match) ? pair_data : fill_q;
    assign refill_done_o = last_beat;
    assign busy_o        = (state_q != IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (miss_i) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (mem_addr_ready_i) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (last_beat) begin
                    state_d = hold_i ? DONE : IDLE;
                end
            end
            DONE: begin
                // two cycles for the held request to get through lookup
                if (beat_cnt_q[0]) begin
                    state_d = miss_i ? REQ : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            beat_cnt_q <= '0;
            victim_q   <= '0;
        end else begin
            state_q <= state_d;
            if (start) begin
                beat_cnt_q <= '0;
            end else if (beat || state_q == DONE) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            if (last_beat) begin
                victim_q[addr_q.f.index] <= ~victim_q[addr_q.f.index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= miss_addr_i;
        end
        if (beat && !beat_cnt_q[0]) begin
            low_word_q <= mem_data_i;
        end
        if (pair_done && pair_match) begin
            fill_q <= pair_data;
        end
    end

endmodule

`default_nettype wire

//--- icache_lookup.sv
`default_nettype none

module icache_lookup (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic                                                     fetch_req_i,
    input  logic [icache_pkg::ADDR_W-1:0]                            fetch_addr_i,
    output logic [icache_pkg::INDEX_W-1:0]                           rd_index_o,
    output logic [icache_pkg::PAIR_SEL_W-1:0]                        rd_pair_o,
    input  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::TAG_W-1:0]    rd_tag_i,
    input  logic [icache_pkg::WAY_NUM-1:0]                           rd_valid_i,
    input  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::PAIR_W-1:0]   rd_data_i,
    output logic                                                     miss_o,
    output logic [icache_pkg::ADDR_W-1:0]                            miss_addr_o,
    output logic                                                     hold_o,
    input  logic                                                     refill_done_i,
    input  logic [icache_pkg::PAIR_W-1:0]                            fill_data_i,
    output logic                                                     resp_valid_o,
    output logic [icache_pkg::ADDR_W-1:0]                            resp_addr_o,
    output logic [icache_pkg::PAIR_W-1:0]                            resp_data_o
);
    import icache_pkg::*;

    logic                s0_valid;
    fetch_addr_u         s0_addr;
    logic                s1_valid_q;
    fetch_addr_u         s1_addr_q;
    logic                wait_q;
    logic                hold_valid_q;
    fetch_addr_u         hold_addr_q;
    logic                replay_q;
    logic                s1_active;
    logic                s1_freeze;
    logic [WAY_NUM-1:0]  hit_way;
    logic [PAIR_W-1:0]   hit_data;

    // stage 0: new request, or the held one once the refill is over
    assign s0_valid   = fetch_req_i || replay_q;
    assign s0_addr    = replay_q ? hold_addr_q : fetch_addr_i;
    assign rd_index_o = s0_addr.f.index;
    assign rd_pair_o  = s0_addr.f.pair;

    // stage 1 compare
    always_comb begin
        hit_data = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_way[w] = rd_valid_i[w] && (rd_tag_i[w] == s1_addr_q.f.tag);
            if (hit_way[w]) begin
                hit_data = rd_data_i[w];
            end
        end
    end

    assign s1_active   = s1_valid_q && !wait_q;
    assign miss_o      = s1_active && !(|hit_way);
    assign miss_addr_o = s1_addr_q.raw;
    assign hold_o      = hold_valid_q;

    // missing request stays in stage 1 until the fill data is back
    assign s1_freeze = miss_o || (wait_q && !refill_done_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid_q   <= 1'b0;
            wait_q       <= 1'b0;
            hold_valid_q <= 1'b0;
            replay_q     <= 1'b0;
            resp_valid_o <= 1'b0;
        end else begin
            if (!s1_freeze) begin
                s1_valid_q <= s0_valid;
            end
            if (miss_o) begin
                wait_q <= 1'b1;
            end else if (refill_done_i) begin
                wait_q <= 1'b0;
            end
            if (miss_o && fetch_req_i) begin
                hold_valid_q <= 1'b1;
            end else if (refill_done_i) begin
                hold_valid_q <= 1'b0;
            end
            replay_q     <= refill_done_i && hold_valid_q;
            resp_valid_o <= refill_done_i || (s1_active && (|hit_way));
        end
    end

    always_ff @(posedge clk) begin
        if (!s1_freeze) begin
            s1_addr_q <= s0_addr;
        end
        if (miss_o && fetch_req_i) begin
            hold_addr_q <= fetch_addr_i;
        end
        if (refill_done_i || s1_active) begin
            resp_addr_o <= s1_addr_q.raw;
            resp_data_o <= refill_done_i ? fill_data_i : hit_data;
        end
    end

endmodule

`default_nettype wire

//--- icache_data_ram.sv
`default_nettype none

module icache_data_ram (
    input  logic                                                     clk,
    input  logic [icache_pkg::INDEX_W-1:0]                           rd_index_i,
    input  logic [icache_pkg::PAIR_SEL_W-1:0]                        rd_pair_i,
    output logic [icache_pkg::WAY_NUM-1:0][icache_pkg::PAIR_W-1:0]   rd_data_o,
    input  logic [icache_pkg::WAY_NUM-1:0]                           wr_en_i,
    input  logic [icache_pkg::INDEX_W-1:0]                           wr_index_i,
    input  logic [icache_pkg::PAIR_SEL_W-1:0]                        wr_pair_i,
    input  logic [icache_pkg::PAIR_W-1:0]                            wr_data_i
);
    import icache_pkg::*;

    // one entry per instruction pair
    logic [PAIR_W-1:0]             data_mem [WAY_NUM][SET_NUM << PAIR_SEL_W];
    logic [INDEX_W+PAIR_SEL_W-1:0] rd_addr;
    logic [INDEX_W+PAIR_SEL_W-1:0] wr_addr;

    assign rd_addr = {rd_index_i, rd_pair_i};
    assign wr_addr = {wr_index_i, wr_pair_i};

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            if (wr_en_i[w]) begin
                data_mem[w][wr_addr] <= wr_data_i;
            end
            rd_data_o[w] <= data_mem[w][rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- icache_tag_ram.sv
`default_nettype none

module icache_tag_ram (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic [icache_pkg::INDEX_W-1:0]                           rd_index_i,
    output logic [icache_pkg::WAY_NUM-1:0][icache_pkg::TAG_W-1:0]    rd_tag_o,
    output logic [icache_pkg::WAY_NUM-1:0]                           rd_valid_o,
    input  logic [icache_pkg::WAY_NUM-1:0]                           wr_en_i,
    input  logic [icache_pkg::INDEX_W-1:0]                           wr_index_i,
    input  logic [icache_pkg::TAG_W-1:0]                             wr_tag_i
);
    import icache_pkg::*;

    logic [TAG_W-1:0]                 tag_mem [WAY_NUM][SET_NUM];
    logic [WAY_NUM-1:0][SET_NUM-1:0]  valid_q;

    // tag array, one port per way
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            if (wr_en_i[w]) begin
                tag_mem[w][wr_index_i] <= wr_tag_i;
            end
            rd_tag_o[w] <= tag_mem[w][rd_index_i];
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_valid_o <= '0;
        end else begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (wr_en_i[w]) begin
                    valid_q[w][wr_index_i] <= 1'b1;
                end
                // read returns the state before this cycle's write
                rd_valid_o[w] <= valid_q[w][rd_index_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    // address and fetch widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int PAIR_W = 2 * WORD_W;

    // cache geometry
    localparam int WAY_NUM     = 2;
    localparam int SET_NUM     = 128;
    localparam int BLOCK_WORDS = 8;

    // address split
    localparam int INDEX_W    = 7;
    localparam int TAG_W      = 20;
    localparam int PAIR_SEL_W = 2;

    // fetch address, either as a raw word or as lookup fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [INDEX_W-1:0]    index;
            logic [PAIR_SEL_W-1:0] pair;
            logic [2:0]            offset;
        } f;
    } fetch_addr_u;

    // miss handling states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        FILL,
        DONE
    } refill_state_e;

endpackage

`default_nettype wire
